//--- rvseed_wb.f
+incdir+bench
design/rvseed_pkg.sv
design/mem_wb_regs.sv
design/wb_select.sv
design/regfile.sv
design/wb_top.sv
bench/tb_wb_top.sv

//--- run_sim.sh
#!/bin/sh
# build the writeback testbench with verilator, run it, judge the run by its log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_wb_top -f rvseed_wb.f \
    --Mdir obj_dir -o sim_wb > build.log 2>&1 \
    || { echo "verilator build failed, see build.log"; exit 1; }

./obj_dir/sim_wb > sim.log 2>&1
cat sim.log

grep -qx "all tests passed" sim.log \
    && echo "simulation result: pass" \
    || { echo "simulation result: fail, see sim.log"; exit 1; }

//--- bench/tb_wb_vectors.svh
// row layout: stim_row(rnd, stall, wen, waddr, alu_res, mem_rdata, is_load, load_kind, pc,
//   ebreak, raddr1, raddr2), then expect_row(mask, wb_wdata, wb_pc, rdata1, rdata2)
// mask bits 3..0 enable the wb_wdata, wb_pc, rdata1, rdata2 checks

localparam int NUM_ROWS = 32;

localparam pc_t   PC0    = 64'h8000_1000;
localparam xlen_t MEM_A  = 64'hf1e2_d3c4_b5a6_9788;  // bytes 88 97 a6 b5 c4 d3 e2 f1
localparam xlen_t MEM_B  = 64'h0123_4567_89ab_cdef;  // bytes ef cd ab 89 67 45 23 01
localparam xlen_t X1_VAL = 64'h1234_5678_9abc_def0;
localparam xlen_t X2_VAL = 64'hfedc_ba98_7654_3210;
localparam xlen_t X4_VAL = 64'h4444_0000_0000_0004;

// stimulus columns
logic       t_rnd    [NUM_ROWS];  // alu_res drawn at random
logic       t_stall  [NUM_ROWS];
logic       t_wen    [NUM_ROWS];
reg_addr_t  t_waddr  [NUM_ROWS];
xlen_t      t_alu    [NUM_ROWS];
xlen_t      t_mdata  [NUM_ROWS];
logic       t_load   [NUM_ROWS];
load_kind_t t_kind   [NUM_ROWS];
pc_t        t_pc     [NUM_ROWS];
logic       t_ebreak [NUM_ROWS];
reg_addr_t  t_ra1    [NUM_ROWS];
reg_addr_t  t_ra2    [NUM_ROWS];

// expected columns
logic [3:0] t_mask   [NUM_ROWS];
xlen_t      t_wdata  [NUM_ROWS];
pc_t        t_epc    [NUM_ROWS];
xlen_t      t_rd1    [NUM_ROWS];
xlen_t      t_rd2    [NUM_ROWS];

int         n_filled;

task automatic stim_row(input logic rnd, input logic stall, input logic wen,
                        input reg_addr_t waddr, input xlen_t alu, input xlen_t mdata,
                        input logic load, input load_kind_t kind, input pc_t pc,
                        input logic ebreak, input reg_addr_t ra1, input reg_addr_t ra2);
    t_rnd[n_filled]    = rnd;
    t_stall[n_filled]  = stall;
    t_wen[n_filled]    = wen;
    t_waddr[n_filled]  = waddr;
    t_alu[n_filled]    = alu;
    t_mdata[n_filled]  = mdata;
    t_load[n_filled]   = load;
    t_kind[n_filled]   = kind;
    t_pc[n_filled]     = pc;
    t_ebreak[n_filled] = ebreak;
    t_ra1[n_filled]    = ra1;
    t_ra2[n_filled]    = ra2;
endtask

// closes the row opened by stim_row
task automatic expect_row(input logic [3:0] mask, input xlen_t wdata, input pc_t pc,
                          input xlen_t rd1, input xlen_t rd2);
    t_mask[n_filled]  = mask;
    t_wdata[n_filled] = wdata;
    t_epc[n_filled]   = pc;
    t_rd1[n_filled]   = rd1;
    t_rd2[n_filled]   = rd2;
    n_filled = n_filled + 1;
endtask

task automatic fill_table();
    n_filled = 0;
    // alu writeback, bypass then storage, x0 write dropped
    stim_row(0, 0, 1, 1, X1_VAL, 64'h0, 0, LD_B, PC0 + 64'h00, 0, 1, 0);
    expect_row(4'b1111, X1_VAL, PC0 + 64'h00, X1_VAL, 64'h0);
    stim_row(0, 0, 1, 2, X2_VAL, 64'h0, 0, LD_B, PC0 + 64'h04, 0, 1, 2);
    expect_row(4'b1111, X2_VAL, PC0 + 64'h04, X1_VAL, X2_VAL);
    stim_row(0, 0, 1, 0, 64'hdead_beef, 64'h0, 0, LD_B, PC0 + 64'h08, 0, 0, 0);
    expect_row(4'b1111, 64'hdead_beef, PC0 + 64'h08, 64'h0, 64'h0);
    stim_row(0, 0, 0, 0, 64'h55, 64'h0, 0, LD_B, PC0 + 64'h0c, 0, 0, 2);
    expect_row(4'b1111, 64'h55, PC0 + 64'h0c, 64'h0, X2_VAL);
    stim_row(0, 0, 0, 0, 64'h0, 64'h0, 0, LD_B, PC0 + 64'h10, 0, 2, 1);
    expect_row(4'b0011, 64'h0, PC0 + 64'h10, X2_VAL, X1_VAL);

    // ebreak, two stalled rows, then resume
    stim_row(0, 0, 1, 3, 64'habc, 64'h0, 0, LD_B, PC0 + 64'h14, 1, 3, 1);
    expect_row(4'b1111, 64'habc, PC0 + 64'h14, 64'habc, X1_VAL);
    stim_row(0, 1, 1, 4, 64'h9999, 64'h0, 0, LD_B, PC0 + 64'h18, 0, 3, 4);
    expect_row(4'b1111, 64'habc, PC0 + 64'h14, 64'habc, 64'h0);
    stim_row(0, 1, 1, 5, 64'h7777, 64'h0, 0, LD_B, PC0 + 64'h1c, 0, 4, 3);
    expect_row(4'b1111, 64'habc, PC0 + 64'h14, 64'h0, 64'habc);
    stim_row(0, 0, 1, 4, X4_VAL, 64'h0, 0, LD_B, PC0 + 64'h18, 0, 4, 3);
    expect_row(4'b1111, X4_VAL, PC0 + 64'h18, X4_VAL, 64'habc);

    // random alu data, wdata and bypass filled in by the bench
    stim_row(1, 0, 1, 6, 64'h0, 64'h0, 0, LD_B, PC0 + 64'h1c, 0, 6, 4);
    expect_row(4'b1111, 64'h0, PC0 + 64'h1c, 64'h0, X4_VAL);
    stim_row(1, 0, 1, 7, 64'h0, 64'h0, 0, LD_B, PC0 + 64'h20, 0, 7, 4);
    expect_row(4'b1111, 64'h0, PC0 + 64'h20, 64'h0, X4_VAL);
    stim_row(1, 0, 1, 0, 64'h0, 64'h0, 0, LD_B, PC0 + 64'h24, 0, 0, 4);
    expect_row(4'b1111, 64'h0, PC0 + 64'h24, 64'h0, X4_VAL);

    // loads into x10, every kind at several byte offsets
    stim_row(0, 0, 1, 10, 64'h1000, MEM_A, 1, LD_B, PC0 + 64'h28, 0, 10, 4);
    expect_row(4'b1111, 64'hffffffffffffff88, PC0 + 64'h28, 64'hffffffffffffff88, X4_VAL);
    stim_row(0, 0, 1, 10, 64'h1003, MEM_A, 1, LD_B, PC0 + 64'h2c, 0, 10, 4);
    expect_row(4'b1111, 64'hffffffffffffffb5, PC0 + 64'h2c, 64'hffffffffffffffb5, X4_VAL);
    stim_row(0, 0, 1, 10, 64'h1004, MEM_B, 1, LD_B, PC0 + 64'h30, 0, 10, 4);
    expect_row(4'b1111, 64'h67, PC0 + 64'h30, 64'h67, X4_VAL);
    stim_row(0, 0, 1, 10, 64'h1000, MEM_A, 1, LD_BU, PC0 + 64'h34, 0, 10, 4);
    expect_row(4'b1111, 64'h88, PC0 + 64'h34, 64'h88, X4_VAL);
    stim_row(0, 0, 1, 10, 64'h1005, MEM_A, 1, LD_BU, PC0 + 64'h38, 0, 10, 4);
    expect_row(4'b1111, 64'hd3, PC0 + 64'h38, 64'hd3, X4_VAL);
    stim_row(0, 0, 1, 10, 64'h1000, MEM_A, 1, LD_H, PC0 + 64'h3c, 0, 10, 4);
    expect_row(4'b1111, 64'hffffffffffff9788, PC0 + 64'h3c, 64'hffffffffffff9788, X4_VAL);
    stim_row(0, 0, 1, 10, 64'h1006, MEM_A, 1, LD_H, PC0 + 64'h40, 0, 10, 4);
    expect_row(4'b1111, 64'hfffffffffffff1e2, PC0 + 64'h40, 64'hfffffffffffff1e2, X4_VAL);
    stim_row(0, 0, 1, 10, 64'h1006, MEM_B, 1, LD_H, PC0 + 64'h44, 0, 10, 4);
    expect_row(4'b1111, 64'h0123, PC0 + 64'h44, 64'h0123, X4_VAL);
    stim_row(0, 0, 1, 10, 64'h1002, MEM_A, 1, LD_HU, PC0 + 64'h48, 0, 10, 4);
    expect_row(4'b1111, 64'hb5a6, PC0 + 64'h48, 64'hb5a6, X4_VAL);
    stim_row(0, 0, 1, 10, 64'h1007, MEM_A, 1, LD_HU, PC0 + 64'h4c, 0, 10, 4);
    expect_row(4'b1111, 64'hf1, PC0 + 64'h4c, 64'hf1, X4_VAL);  // upper lane runs out
    stim_row(0, 0, 1, 10, 64'h1000, MEM_A, 1, LD_W, PC0 + 64'h50, 0, 10, 4);
    expect_row(4'b1111, 64'hffffffffb5a69788, PC0 + 64'h50, 64'hffffffffb5a69788, X4_VAL);
    stim_row(0, 0, 1, 10, 64'h1004, MEM_A, 1, LD_W, PC0 + 64'h54, 0, 10, 4);
    expect_row(4'b1111, 64'hfffffffff1e2d3c4, PC0 + 64'h54, 64'hfffffffff1e2d3c4, X4_VAL);
    stim_row(0, 0, 1, 10, 64'h1004, MEM_B, 1, LD_W, PC0 + 64'h58, 0, 10, 4);
    expect_row(4'b1111, 64'h01234567, PC0 + 64'h58, 64'h01234567, X4_VAL);
    stim_row(0, 0, 1, 10, 64'h1000, MEM_A, 1, LD_WU, PC0 + 64'h5c, 0, 10, 4);
    expect_row(4'b1111, 64'hb5a69788, PC0 + 64'h5c, 64'hb5a69788, X4_VAL);
    stim_row(0, 0, 1, 10, 64'h1004, MEM_A, 1, LD_WU, PC0 + 64'h60, 0, 10, 4);
    expect_row(4'b1111, 64'hf1e2d3c4, PC0 + 64'h60, 64'hf1e2d3c4, X4_VAL);
    stim_row(0, 0, 1, 10, 64'h1000, MEM_A, 1, LD_D, PC0 + 64'h64, 0, 10, 4);
    expect_row(4'b1111, MEM_A, PC0 + 64'h64, MEM_A, X4_VAL);
    stim_row(0, 0, 1, 10, 64'h1004, MEM_A, 1, LD_D, PC0 + 64'h68, 0, 10, 4);
    expect_row(4'b1111, 64'hf1e2d3c4, PC0 + 64'h68, 64'hf1e2d3c4, X4_VAL);
    stim_row(0, 0, 1, 10, 64'h1000, MEM_B, 1, LD_D, PC0 + 64'h6c, 0, 10, 4);
    expect_row(4'b1111, MEM_B, PC0 + 64'h6c, MEM_B, X4_VAL);

    // stalled load, then a plain readback of two registers
    stim_row(0, 1, 1, 11, 64'h2000, MEM_A, 1, LD_B, PC0 + 64'h70, 0, 10, 11);
    expect_row(4'b1111, MEM_B, PC0 + 64'h6c, MEM_B, 64'h0);
    stim_row(0, 0, 0, 11, 64'h3000, MEM_A, 0, LD_B, PC0 + 64'h70, 0, 10, 2);
    expect_row(4'b1111, 64'h3000, PC0 + 64'h70, MEM_B, X2_VAL);
endtask

//--- bench/tb_wb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_wb_top;
    import rvseed_pkg::*;

    localparam int RESET_CYCLES = 3;

    logic       clk;
    logic       rst_n;
    logic       stall_i;
    logic       reg_wen_i;
    reg_addr_t  reg_waddr_i;
    xlen_t      alu_res_i;
    xlen_t      mem_rdata_i;
    logic       is_load_i;
    load_kind_t load_kind_i;
    pc_t        pc_i;
    logic       ebreak_i;
    reg_addr_t  raddr1_i;
    reg_addr_t  raddr2_i;

    logic       wb_wen_o;
    reg_addr_t  wb_waddr_o;
    xlen_t      wb_wdata_o;
    pc_t        wb_pc_o;
    logic       ebreak_o;
    xlen_t      rdata1_o;
    xlen_t      rdata2_o;

    integer     seed;
    int         errors;
    int         cycles;
    int         row;

    // stage fields as they should stand, held through stalls
    logic       exp_wen;
    reg_addr_t  exp_waddr;
    logic       exp_ebreak;

    `include "tb_wb_vectors.svh"

    localparam int CYCLE_LIMIT = 2 * NUM_ROWS + RESET_CYCLES + 20;  // two cycles per row

    wb_top u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall_i     (stall_i),
        .reg_wen_i   (reg_wen_i),
        .reg_waddr_i (reg_waddr_i),
        .alu_res_i   (alu_res_i),
        .mem_rdata_i (mem_rdata_i),
        .is_load_i   (is_load_i),
        .load_kind_i (load_kind_i),
        .pc_i        (pc_i),
        .ebreak_i    (ebreak_i),
        .raddr1_i    (raddr1_i),
        .raddr2_i    (raddr2_i),
        .wb_wen_o    (wb_wen_o),
        .wb_waddr_o  (wb_waddr_o),
        .wb_wdata_o  (wb_wdata_o),
        .wb_pc_o     (wb_pc_o),
        .ebreak_o    (ebreak_o),
        .rdata1_o    (rdata1_o),
        .rdata2_o    (rdata2_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    task automatic check_value(input string what, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            errors = errors + 1;
            $display("FAIL %0t ns: row %0d %s is %h, expected %h",
                     $time, row, what, actual, expected);
        end
    endtask

    // watchdog
    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        $display("timeout: the test loop did not finish within %0d clock cycles", cycles);
        $display("tests failed");
        $finish;
    end

    initial begin
        xlen_t      rnd_val;
        xlen_t      exp_wdata;
        xlen_t      exp_rd1;
        xlen_t      exp_rd2;
        logic [3:0] mask;

        seed        = 32'h44f2_f612;
        errors      = 0;
        row         = -1;  // reset phase
        rst_n       = 1'b0;
        stall_i     = 1'b0;
        reg_wen_i   = 1'b0;
        reg_waddr_i = '0;
        alu_res_i   = '0;
        mem_rdata_i = '0;
        is_load_i   = 1'b0;
        load_kind_i = LD_B;
        pc_i        = '0;
        ebreak_i    = 1'b0;
        raddr1_i    = 5'd5;
        raddr2_i    = 5'd31;
        exp_wen     = 1'b0;
        exp_waddr   = '0;
        exp_ebreak  = 1'b0;

        fill_table();
        if (n_filled != NUM_ROWS) begin
            $display("vector table holds %0d rows instead of %0d", n_filled, NUM_ROWS);
            errors = errors + 1;
        end

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        // state straight out of reset
        @(negedge clk);
        check_value("wb_wen_o", 64'(wb_wen_o), 64'h0);
        check_value("wb_waddr_o", 64'(wb_waddr_o), 64'h0);
        check_value("wb_pc_o", wb_pc_o, PC_RESET);
        check_value("ebreak_o", 64'(ebreak_o), 64'h0);
        check_value("rdata1_o", rdata1_o, 64'h0);
        check_value("rdata2_o", rdata2_o, 64'h0);

        for (row = 0; row < NUM_ROWS; row++) begin
            @(posedge clk);
            rnd_val = t_alu[row];
            if (t_rnd[row]) begin
                rnd_val = {$random(seed), $random(seed)};
            end
            stall_i     <= t_stall[row];
            reg_wen_i   <= t_wen[row];
            reg_waddr_i <= t_waddr[row];
            alu_res_i   <= rnd_val;
            mem_rdata_i <= t_mdata[row];
            is_load_i   <= t_load[row];
            load_kind_i <= t_kind[row];
            pc_i        <= t_pc[row];
            ebreak_i    <= t_ebreak[row];
            raddr1_i    <= t_ra1[row];
            raddr2_i    <= t_ra2[row];

            mask      = t_mask[row];
            exp_wdata = t_wdata[row];
            exp_rd1   = t_rd1[row];
            exp_rd2   = t_rd2[row];
            // random rows are plain alu writes, readable through the bypass
            if (t_rnd[row]) begin
                exp_wdata = rnd_val;
                if (t_wen[row] && t_waddr[row] != '0 && t_ra1[row] == t_waddr[row])
                    exp_rd1 = rnd_val;
                if (t_wen[row] && t_waddr[row] != '0 && t_ra2[row] == t_waddr[row])
                    exp_rd2 = rnd_val;
            end
            if (!t_stall[row]) begin
                exp_wen    = t_wen[row];
                exp_waddr  = t_waddr[row];
                exp_ebreak = t_ebreak[row];
            end

            @(posedge clk);  // capture edge
            @(negedge clk);
            check_value("wb_wen_o", 64'(wb_wen_o), 64'(exp_wen));
            check_value("wb_waddr_o", 64'(wb_waddr_o), 64'(exp_waddr));
            check_value("ebreak_o", 64'(ebreak_o), 64'(exp_ebreak));
            if (mask[3]) check_value("wb_wdata_o", wb_wdata_o, exp_wdata);
            if (mask[2]) check_value("wb_pc_o", wb_pc_o, t_epc[row]);
            if (mask[1]) check_value("rdata1_o", rdata1_o, exp_rd1);
            if (mask[0]) check_value("rdata2_o", rdata2_o, exp_rd2);
        end

        $display("%0d rows applied, %0d errors", NUM_ROWS, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- design/wb_top.sv
`timescale 1ns/1ps
`default_nettype none

module wb_top (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         stall_i,      // hold the mem/wb stage

    // memory-stage fields
    input  wire                         reg_wen_i,
    input  wire rvseed_pkg::reg_addr_t  reg_waddr_i,
    input  wire rvseed_pkg::xlen_t      alu_res_i,
    input  wire rvseed_pkg::xlen_t      mem_rdata_i,
    input  wire                         is_load_i,
    input  wire rvseed_pkg::load_kind_t load_kind_i,
    input  wire rvseed_pkg::pc_t        pc_i,
    input  wire                         ebreak_i,

    // register file read addresses, normally from decode
    input  wire rvseed_pkg::reg_addr_t  raddr1_i,
    input  wire rvseed_pkg::reg_addr_t  raddr2_i,

    // writeback view
    output logic                        wb_wen_o,
    output rvseed_pkg::reg_addr_t       wb_waddr_o,
    output rvseed_pkg::xlen_t           wb_wdata_o,
    output rvseed_pkg::pc_t             wb_pc_o,
    output logic                        ebreak_o,     // retiring ebreak, for the sim env

    // read data
    output rvseed_pkg::xlen_t           rdata1_o,
    output rvseed_pkg::xlen_t           rdata2_o
);
    import rvseed_pkg::*;

    // registered fields only used inside writeback
    xlen_t      wb_alu_res;
    xlen_t      wb_mem_rdata;
    logic       wb_is_load;
    load_kind_t wb_load_kind;

    mem_wb_regs u_mem_wb (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall_i     (stall_i),
        .reg_wen_i   (reg_wen_i),
        .reg_waddr_i (reg_waddr_i),
        .alu_res_i   (alu_res_i),
        .mem_rdata_i (mem_rdata_i),
        .is_load_i   (is_load_i),
        .load_kind_i (load_kind_i),
        .pc_i        (pc_i),
        .ebreak_i    (ebreak_i),
        .reg_waddr_o (wb_waddr_o),
        .reg_wen_o   (wb_wen_o),
        .alu_res_o   (wb_alu_res),
        .mem_rdata_o (wb_mem_rdata),
        .is_load_o   (wb_is_load),
        .load_kind_o (wb_load_kind),
        .pc_o        (wb_pc_o),
        .ebreak_o    (ebreak_o)
    );

    // load alignment and result mux
    wb_select u_wb_select (
        .alu_res_i   (wb_alu_res),
        .mem_rdata_i (wb_mem_rdata),
        .is_load_i   (wb_is_load),
        .load_kind_i (wb_load_kind),
        .wdata_o     (wb_wdata_o)
    );

    // written from the registered stage, same value visible on wb_wdata_o
    regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .wen_i    (wb_wen_o),
        .waddr_i  (wb_waddr_o),
        .wdata_i  (wb_wdata_o),
        .raddr1_i (raddr1_i),
        .raddr2_i (raddr2_i),
        .rdata1_o (rdata1_o),
        .rdata2_o (rdata2_o)
    );

endmodule

`default_nettype wire

//--- design/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  wire                        clk,
    input  wire                        rst_n,

    // write port from writeback
    input  wire                        wen_i,
    input  wire rvseed_pkg::reg_addr_t waddr_i,
    input  wire rvseed_pkg::xlen_t     wdata_i,

    // two read ports
    input  wire rvseed_pkg::reg_addr_t raddr1_i,
    input  wire rvseed_pkg::reg_addr_t raddr2_i,
    output rvseed_pkg::xlen_t          rdata1_o,
    output rvseed_pkg::xlen_t          rdata2_o
);
    import rvseed_pkg::*;

    xlen_t regs [REG_DEPTH];
    logic  wr_live;  // a real write this cycle
    logic  byp1;
    logic  byp2;

    assign wr_live = wen_i && (waddr_i != '0);  // x0 writes dropped

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // write-through so a reader sees the value in the writing cycle
    assign byp1 = wr_live && (raddr1_i == waddr_i);
    assign byp2 = wr_live && (raddr2_i == waddr_i);

    // x0 is never written and never bypassed, so its entry stays at the reset zero
    assign rdata1_o = byp1 ? wdata_i : regs[raddr1_i];
    assign rdata2_o = byp2 ? wdata_i : regs[raddr2_i];

    // x0 reads as zero on both ports whatever the write port does
    a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
        ((raddr1_i != '0) || (rdata1_o == '0)) && ((raddr2_i != '0) || (rdata2_o == '0)))
        else $error("regfile: x0 read returned nonzero data");

endmodule

`default_nettype wire

//--- design/wb_select.sv
`timescale 1ns/1ps
`default_nettype none

module wb_select (
    input  wire rvseed_pkg::xlen_t      alu_res_i,    // alu result, doubles as load address
    input  wire rvseed_pkg::xlen_t      mem_rdata_i,  // doubleword as read from memory
    input  wire                         is_load_i,
    input  wire rvseed_pkg::load_kind_t load_kind_i,
    output rvseed_pkg::xlen_t           wdata_o       // value for the register file
);
    import rvseed_pkg::*;

    logic [2:0] byte_off;
    logic [5:0] shamt;
    xlen_t      aligned;
    xlen_t      load_val;

    // low address bits pick the byte lane inside the doubleword
    assign byte_off = alu_res_i[2:0];
    assign shamt    = {byte_off, 3'b000};  // bytes to bits
    assign aligned  = mem_rdata_i >> shamt;

    // extend the aligned value by load kind
    always_comb begin
        case (load_kind_i)
            LD_B: begin
                load_val = {{(XLEN-8){aligned[7]}}, aligned[7:0]};
            end
            LD_H: begin
                load_val = {{(XLEN-16){aligned[15]}}, aligned[15:0]};
            end
            LD_W: begin
                load_val = {{(XLEN-32){aligned[31]}}, aligned[31:0]};
            end
            LD_D: begin
                load_val = aligned;  // full width, offset is normally zero here
            end
            LD_BU: begin
                load_val = {{(XLEN-8){1'b0}}, aligned[7:0]};
            end
            LD_HU: begin
                load_val = {{(XLEN-16){1'b0}}, aligned[15:0]};
            end
            LD_WU: begin
                load_val = {{(XLEN-32){1'b0}}, aligned[31:0]};
            end
            default: begin
                load_val = aligned;
            end
        endcase
    end

    // misaligned accesses are not trapped at this stage;
    // the upper lanes simply shift in zeros
    assign wdata_o = is_load_i ? load_val : alu_res_i;

    // decode must never hand over the unused load code with a live load
    always_comb begin
        if (is_load_i) begin
            assert (load_kind_i <= LD_WU)
                else $error("wb_select: undefined load kind %0d", load_kind_i);
        end
    end

endmodule

`default_nettype wire

//--- design/mem_wb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb_regs (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         stall_i,      // freeze the stage

    // fields from the memory stage
    input  wire                         reg_wen_i,    // register write enable
    input  wire rvseed_pkg::reg_addr_t  reg_waddr_i,  // destination register
    input  wire rvseed_pkg::xlen_t      alu_res_i,    // alu result or load address
    input  wire rvseed_pkg::xlen_t      mem_rdata_i,  // raw doubleword from memory
    input  wire                         is_load_i,
    input  wire rvseed_pkg::load_kind_t load_kind_i,
    input  wire rvseed_pkg::pc_t        pc_i,
    input  wire                         ebreak_i,

    // registered copies for writeback
    output rvseed_pkg::reg_addr_t       reg_waddr_o,
    output logic                        reg_wen_o,
    output rvseed_pkg::xlen_t           alu_res_o,
    output rvseed_pkg::xlen_t           mem_rdata_o,
    output logic                        is_load_o,
    output rvseed_pkg::load_kind_t      load_kind_o,
    output rvseed_pkg::pc_t             pc_o,
    output logic                        ebreak_o
);
    import rvseed_pkg::*;

    // every field captures together, or every field holds together
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_wen_o   <= 1'b0;
            reg_waddr_o <= '0;
            alu_res_o   <= '0;
            mem_rdata_o <= '0;
            is_load_o   <= 1'b0;
            load_kind_o <= LD_B;
            pc_o        <= PC_RESET;  // boot address, not zero
            ebreak_o    <= 1'b0;
        end else if (!stall_i) begin
            reg_wen_o   <= reg_wen_i;
            reg_waddr_o <= reg_waddr_i;
            alu_res_o   <= alu_res_i;
            mem_rdata_o <= mem_rdata_i;
            is_load_o   <= is_load_i;
            load_kind_o <= load_kind_i;
            pc_o        <= pc_i;
            ebreak_o    <= ebreak_i;
        end
        // stall high: all fields keep their value.
        // the held write simply repeats into the register file
    end

    // a stalled edge must leave the whole stage untouched, pc and ebreak included
    property p_stall_holds;
        @(posedge clk) disable iff (!rst_n)
            $past(stall_i) |-> $stable({reg_wen_o, reg_waddr_o, alu_res_o, mem_rdata_o,
                                        is_load_o, load_kind_o, pc_o, ebreak_o});
    endproperty

    a_stall_holds: assert property (p_stall_holds)
        else $error("mem_wb_regs: outputs changed after a stalled edge");

endmodule

`default_nettype wire

//--- design/rvseed_pkg.sv
`default_nettype none

package rvseed_pkg;

    // datapath widths
    localparam int XLEN           = 64;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int REG_DEPTH      = 1 << REG_ADDR_WIDTH;  // 32 integer registers

    // word, register index and pc types
    typedef logic [XLEN-1:0]           xlen_t;      // data words, alu results, addresses
    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [XLEN-1:0]           pc_t;

    // boot address
    localparam pc_t PC_RESET = 64'h8000_0000;

    // load kind encoding, carried from decode with the load
    typedef logic [2:0] load_kind_t;

    localparam load_kind_t LD_B  = 3'd0;  // lb, sign from bit 7
    localparam load_kind_t LD_H  = 3'd1;  // lh, sign from bit 15
    localparam load_kind_t LD_W  = 3'd2;  // lw, sign from bit 31
    localparam load_kind_t LD_D  = 3'd3;  // ld, full doubleword
    localparam load_kind_t LD_BU = 3'd4;
    localparam load_kind_t LD_HU = 3'd5;
    localparam load_kind_t LD_WU = 3'd6;  // highest defined code

    // 3'd7 is unused; writeback treats it as a raw aligned word

endpackage

`default_nettype wire
